/* source/fft_pkg.sv */
// shared widths, sample types and sequencer states used by every block of the 16-point FFT
package fft_pkg;

    localparam int N_POINTS   = 16;
    localparam int N_LEVELS   = 4;
    localparam int IN_W       = 12;
    localparam int DATA_W     = 16;
    localparam int CREDIT_MAX = 4;

    typedef logic signed [IN_W-1:0]   in_word_t;
    typedef logic signed [DATA_W-1:0] data_t;

    // sample position inside a frame, also used as bin index
    typedef logic [3:0] point_t;

    // twiddle angle in steps of 22.5 degrees
    typedef logic [2:0] angle_t;

    typedef logic [2:0] credit_t;

    typedef struct packed {
        in_word_t re;
        in_word_t im;
    } in_sample_t;

    typedef struct packed {
        data_t re;
        data_t im;
    } cplx_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH
    } ctrl_state_e;

endpackage

/* source/delay_line.sv */
// complex shift register of configurable depth used as the feedback delay in each stage
module delay_line
#(
    parameter int unsigned DEPTH = 1
)
(
    input  logic           clk,
    input  logic           rst_n,
    input  fft_pkg::cplx_t d_i,
    output fft_pkg::cplx_t q_o
);

    fft_pkg::cplx_t sr_q [DEPTH];

    assign q_o = sr_q[DEPTH-1];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
                sr_q[i] <= '0;
        end
        else
        begin
            sr_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++)
                sr_q[i] <= sr_q[i-1];
        end
    end

endmodule

/* source/twiddle_rotator.sv */
// multiplies a complex value by exp(-j*angle*22.5deg) using shift and add constants
module twiddle_rotator
(
    input  fft_pkg::cplx_t  x_i,
    input  fft_pkg::angle_t angle_i,
    output fft_pkg::cplx_t  y_o
);

    fft_pkg::data_t c22_re, c22_im;
    fft_pkg::data_t s22_re, s22_im;
    fft_pkg::data_t c45_re, c45_im;

    // 1 - 1/16 - 1/64, close to cos 22.5
    function automatic fft_pkg::data_t cos22(input fft_pkg::data_t v);
        return v - (v >>> 4) - (v >>> 6);
    endfunction

    // 1/2 - 1/8, close to sin 22.5
    function automatic fft_pkg::data_t sin22(input fft_pkg::data_t v);
        return (v >>> 1) - (v >>> 3);
    endfunction

    // 1 - 1/4 - 1/16 + 1/64, close to cos 45
    function automatic fft_pkg::data_t cos45(input fft_pkg::data_t v);
        return v - (v >>> 2) - (v >>> 4) + (v >>> 6);
    endfunction

    assign c22_re = cos22(x_i.re);
    assign c22_im = cos22(x_i.im);
    assign s22_re = sin22(x_i.re);
    assign s22_im = sin22(x_i.im);
    assign c45_re = cos45(x_i.re);
    assign c45_im = cos45(x_i.im);

    // re' = re*cos + im*sin, im' = im*cos - re*sin
    always_comb
    begin
        y_o = x_i;
        case (angle_i)
            3'd1:
            begin
                y_o.re = c22_re + s22_im;
                y_o.im = c22_im - s22_re;
            end
            3'd2:
            begin
                y_o.re = c45_re + c45_im;
                y_o.im = c45_im - c45_re;
            end
            3'd3:
            begin
                y_o.re = s22_re + c22_im;
                y_o.im = s22_im - c22_re;
            end
            3'd4:
            begin
                y_o.re = x_i.im;
                y_o.im = -x_i.re;
            end
            3'd5:
            begin
                y_o.re = c22_im - s22_re;
                y_o.im = -s22_im - c22_re;
            end
            3'd6:
            begin
                y_o.re = c45_im - c45_re;
                y_o.im = -c45_im - c45_re;
            end
            3'd7:
            begin
                y_o.re = s22_im - c22_re;
                y_o.im = -c22_im - s22_re;
            end
            default:
                y_o = x_i;
        endcase
    end

endmodule

/* source/mdc_stage.sv */
// one radix-2 decimation-in-frequency level with commutator, butterfly and twiddle rotation
module mdc_stage
#(
    parameter int unsigned LEVEL = 0
)
(
    input  logic            clk,
    input  logic            rst_n,
    input  fft_pkg::point_t pos_i,
    input  fft_pkg::cplx_t  upper_i,
    input  fft_pkg::cplx_t  lower_i,
    output fft_pkg::cplx_t  upper_o,
    output fft_pkg::cplx_t  lower_o
);

    fft_pkg::cplx_t  lower_dly;
    fft_pkg::cplx_t  to_dly;
    fft_pkg::cplx_t  bfly_a;
    fft_pkg::cplx_t  bfly_b;
    fft_pkg::cplx_t  diff;
    fft_pkg::point_t pos_low;
    fft_pkg::angle_t angle;
    logic            swap;

    // the rotated difference of the level above is aligned here on entry
    delay_line #(.DEPTH(2 ** LEVEL)) u_lower_dly
    (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (lower_i),
        .q_o   (lower_dly)
    );

    assign swap   = pos_i[LEVEL];
    assign to_dly = swap ? lower_dly : upper_i;
    assign bfly_b = swap ? upper_i : lower_dly;

    delay_line #(.DEPTH(2 ** LEVEL)) u_upper_dly
    (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (to_dly),
        .q_o   (bfly_a)
    );

    assign upper_o = '{re: bfly_a.re + bfly_b.re, im: bfly_a.im + bfly_b.im};
    assign diff    = '{re: bfly_a.re - bfly_b.re, im: bfly_a.im - bfly_b.im};

    // W of the 2^(LEVEL+1) block, expressed in 22.5 degree steps
    assign pos_low = pos_i & fft_pkg::point_t'((1 << LEVEL) - 1);
    assign angle   = fft_pkg::angle_t'(pos_low << (fft_pkg::N_LEVELS - 1 - LEVEL));

    twiddle_rotator u_twiddle
    (
        .x_i     (diff),
        .angle_i (angle),
        .y_o     (lower_o)
    );

endmodule

/* source/fft_ctrl.sv */
// frame sequencer that steps the shared sample position and marks the cycles carrying result pairs
module fft_ctrl
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid_i,
    input  logic            frame_done_i,
    output fft_pkg::point_t pos_o,
    output logic            results_valid_o,
    output logic            in_ready_o
);

    fft_pkg::ctrl_state_e state_q, state_d;
    fft_pkg::point_t      pos_q, pos_d;
    fft_pkg::point_t      pair_cnt_q, pair_cnt_d;

    assign pos_o      = pos_q;
    assign in_ready_o = (state_q == fft_pkg::IDLE);

    // one pair per cycle until the whole frame has left stage 0
    assign results_valid_o = (state_q == fft_pkg::FLUSH)
        && (pair_cnt_q != fft_pkg::point_t'(fft_pkg::N_POINTS / 2));

    always_comb
    begin
        state_d    = state_q;
        pos_d      = pos_q;
        pair_cnt_d = pair_cnt_q;
        case (state_q)
            fft_pkg::IDLE:
            begin
                pos_d      = '0;
                pair_cnt_d = '0;
                if (in_valid_i)
                    state_d = fft_pkg::RUN;
            end
            fft_pkg::RUN:
            begin
                pos_d = pos_q + 1'b1;
                // pipeline fill is one cycle short of a frame
                if (pos_q == fft_pkg::point_t'(fft_pkg::N_POINTS - 2))
                    state_d = fft_pkg::FLUSH;
            end
            default:
            begin
                pos_d = pos_q + 1'b1;
                if (results_valid_o)
                    pair_cnt_d = pair_cnt_q + 1'b1;
                if (frame_done_i)
                    state_d = fft_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= fft_pkg::IDLE;
            pos_q      <= '0;
            pair_cnt_q <= '0;
        end
        else
        begin
            state_q    <= state_d;
            pos_q      <= pos_d;
            pair_cnt_q <= pair_cnt_d;
        end
    end

    // a frame may only start while the reorder buffer has been drained
    a_frame_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid_i) |-> state_q == fft_pkg::IDLE)
        else $error("frame started while the previous one is still in flight");

endmodule

/* source/reorder_buffer.sv */
// frame buffer written in bit-reversed order and read out in natural order, one bin per credit
module reorder_buffer
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en_i,
    input  fft_pkg::point_t      wr_pos_i,
    // index 1 carries the upper stream, index 0 the lower
    input  fft_pkg::cplx_t [1:0] pair_i,
    input  logic                 credit_i,
    output logic                 frame_done_o,
    output logic                 out_valid_o,
    output fft_pkg::cplx_t       dout_o
);

    fft_pkg::cplx_t   mem [fft_pkg::N_POINTS];
    fft_pkg::cplx_t   dout_q;
    fft_pkg::point_t  wr_pos_odd;
    fft_pkg::point_t  rd_ptr_q;
    fft_pkg::credit_t credit_q, credit_d;
    logic             filled_q;
    logic             last_wr;
    logic             last_rd;
    logic             send;
    logic             credit_take;
    logic             out_valid_q;
    logic             done_q;

    function automatic fft_pkg::point_t bit_rev(input fft_pkg::point_t p);
        fft_pkg::point_t r;
        for (int b = 0; b < $bits(p); b++)
            r[b] = p[$bits(p) - 1 - b];
        return r;
    endfunction

    assign wr_pos_odd = wr_pos_i + fft_pkg::point_t'(1);
    assign last_wr    = wr_en_i && (wr_pos_i == fft_pkg::point_t'(fft_pkg::N_POINTS - 2));
    assign send       = filled_q && (credit_q != '0);
    assign last_rd    = send && (rd_ptr_q == fft_pkg::point_t'(fft_pkg::N_POINTS - 1));

    // a credit at a full count is only kept when a bin leaves in the same cycle
    assign credit_take = credit_i
        && ((credit_q != fft_pkg::credit_t'(fft_pkg::CREDIT_MAX)) || send);

    always_comb
    begin
        credit_d = credit_q;
        if (credit_take)
            credit_d = credit_d + 1'b1;
        if (send)
            credit_d = credit_d - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            filled_q    <= 1'b0;
            rd_ptr_q    <= '0;
            credit_q    <= '0;
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end
        else
        begin
            credit_q    <= credit_d;
            out_valid_q <= send;
            done_q      <= last_rd;
            if (send)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (last_wr)
                filled_q <= 1'b1;
            else if (last_rd)
                filled_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem[bit_rev(wr_pos_i)]   <= pair_i[1];
            mem[bit_rev(wr_pos_odd)] <= pair_i[0];
        end
        if (send)
            dout_q <= mem[rd_ptr_q];
    end

    assign out_valid_o  = out_valid_q;
    assign dout_o       = dout_q;
    assign frame_done_o = done_q;

    // the sink must not return more credits than the buffer can count
    a_no_lost_credit: assert property (@(posedge clk) disable iff (!rst_n)
        credit_i && (credit_q == fft_pkg::credit_t'(fft_pkg::CREDIT_MAX)) |-> send)
        else $error("credit returned while the count is already at its maximum");

endmodule

/* source/fft_top.sv */
// top level that registers the input frame and runs it through four stages into the reorder buffer
module fft_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid_i,
    input  fft_pkg::in_sample_t din_i,
    output logic                in_ready_o,
    input  logic                credit_i,
    output logic                out_valid_o,
    output fft_pkg::cplx_t      dout_o
);

    fft_pkg::in_sample_t din_q;
    fft_pkg::cplx_t      upper [fft_pkg::N_LEVELS + 1];
    fft_pkg::cplx_t      lower [fft_pkg::N_LEVELS + 1];
    fft_pkg::point_t     pos;
    fft_pkg::point_t     wr_pos;
    logic                results_valid;
    logic                frame_done;

    // samples outside a frame enter as zeros
    always_ff @(posedge clk)
    begin
        din_q <= in_valid_i ? din_i : '0;
    end

    assign upper[fft_pkg::N_LEVELS] = '{re: fft_pkg::data_t'(din_q.re),
                                        im: fft_pkg::data_t'(din_q.im)};
    assign lower[fft_pkg::N_LEVELS] = '0;

    // stage 0 completes pair k while the position reads k-1
    assign wr_pos = fft_pkg::point_t'({pos + fft_pkg::point_t'(1), 1'b0});

    fft_ctrl u_ctrl
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .frame_done_i    (frame_done),
        .pos_o           (pos),
        .results_valid_o (results_valid),
        .in_ready_o      (in_ready_o)
    );

    // highest level first, its delay spans half a frame
    for (genvar g = 0; g < fft_pkg::N_LEVELS; g++)
    begin : g_stage
        mdc_stage #(.LEVEL(g)) u_stage
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .pos_i   (pos),
            .upper_i (upper[g + 1]),
            .lower_i (lower[g + 1]),
            .upper_o (upper[g]),
            .lower_o (lower[g])
        );
    end

    reorder_buffer u_reorder
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en_i      (results_valid),
        .wr_pos_i     (wr_pos),
        .pair_i       ({upper[0], lower[0]}),
        .credit_i     (credit_i),
        .frame_done_o (frame_done),
        .out_valid_o  (out_valid_o),
        .dout_o       (dout_o)
    );

endmodule

/* tb/fft_checker.sv */
// testbench monitor that counts credits and compares every output bin with the expected spectrum
module fft_checker
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_start_i,
    input  logic [1:0]        code_i,
    input  fft_pkg::in_word_t amp_i,
    input  logic              credit_i,
    input  logic              out_valid_i,
    input  fft_pkg::cplx_t    dout_i,
    output int                held_o,
    output int                frames_o,
    output int                value_errs_o,
    output int                flow_errs_o
);

    localparam logic [1:0] PAT_IMPULSE   = 2'd0;
    localparam logic [1:0] PAT_CONSTANT  = 2'd1;
    localparam logic [1:0] PAT_ALTERNATE = 2'd2;

    typedef struct packed {
        logic [1:0]        code;
        fft_pkg::in_word_t amp;
    } frame_t;

    frame_t pending [$];
    frame_t cur;
    int     bin_idx;
    int     exp_re;

    // only the real part can be nonzero for the frame patterns in use
    function automatic int expected_re(input frame_t f, input int k);
        int full;
        full = fft_pkg::N_POINTS * int'(f.amp);
        case (f.code)
            PAT_IMPULSE:
                return int'(f.amp);
            PAT_CONSTANT:
                return (k == 0) ? full : 0;
            PAT_ALTERNATE:
                return (k == fft_pkg::N_POINTS / 2) ? full : 0;
            default:
                return (k == fft_pkg::N_POINTS / 4) ? full : 0;
        endcase
    endfunction

    // mid-cycle sampling, inputs and outputs are both settled here
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            held_o       = 0;
            frames_o     = 0;
            value_errs_o = 0;
            flow_errs_o  = 0;
            bin_idx      = 0;
        end
        else
        begin
            if (frame_start_i)
                pending.push_back('{code: code_i, amp: amp_i});
            if (out_valid_i)
            begin
                if (held_o == 0)
                begin
                    $display("time %0t: output bin sent with no credit outstanding", $time);
                    flow_errs_o++;
                end
                else
                    held_o--;
                if (pending.size() == 0)
                begin
                    $display("time %0t: output bin appeared with no frame in flight", $time);
                    flow_errs_o++;
                end
                else
                begin
                    cur    = pending[0];
                    exp_re = expected_re(cur, bin_idx);
                    if (dout_i.re !== fft_pkg::data_t'(exp_re))
                    begin
                        $display("Error at time %0t: dout_o.re of bin %0d is %0d, expected %0d",
                                 $time, bin_idx, dout_i.re, exp_re);
                        value_errs_o++;
                    end
                    if (dout_i.im !== '0)
                    begin
                        $display("Error at time %0t: dout_o.im of bin %0d is %0d, expected 0",
                                 $time, bin_idx, dout_i.im);
                        value_errs_o++;
                    end
                    bin_idx++;
                    if (bin_idx == fft_pkg::N_POINTS)
                    begin
                        bin_idx = 0;
                        void'(pending.pop_front());
                        frames_o++;
                    end
                end
            end
            // a credit seen in this cycle can only release a later bin
            if (credit_i)
                held_o++;
        end
    end

endmodule

/* tb/tb_fft.sv */
// testbench top that sends a table of test frames to the FFT and returns credits for the results
module tb_fft;

    localparam int NUM_ROWS     = 10;
    localparam int LFSR_SEED    = 5;
    localparam int READY_LIMIT  = 1000;
    localparam int CREDIT_LIMIT = 1000;

    localparam logic [1:0] PAT_IMPULSE   = 2'd0;
    localparam logic [1:0] PAT_CONSTANT  = 2'd1;
    localparam logic [1:0] PAT_ALTERNATE = 2'd2;
    localparam logic [1:0] PAT_ROTATE    = 2'd3;

    typedef struct packed {
        logic [1:0]        code;
        fft_pkg::in_word_t amp;
        logic              gapped;
        logic [7:0]        hold;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    fft_pkg::in_sample_t din;
    logic                in_ready;
    logic                credit;
    logic                out_valid;
    fft_pkg::cplx_t      dout;
    logic                frame_start;
    logic [1:0]          cur_code;
    fft_pkg::in_word_t   cur_amp;
    logic [15:0]         lfsr;
    row_t                stim [NUM_ROWS];
    int                  held;
    int                  frames;
    int                  value_errs;
    int                  flow_errs;
    int                  tb_errs;
    logic                aborted;

    fft_top u_dut
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid),
        .din_i       (din),
        .in_ready_o  (in_ready),
        .credit_i    (credit),
        .out_valid_o (out_valid),
        .dout_o      (dout)
    );

    fft_checker u_chk
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_start_i (frame_start),
        .code_i        (cur_code),
        .amp_i         (cur_amp),
        .credit_i      (credit),
        .out_valid_i   (out_valid),
        .dout_i        (dout),
        .held_o        (held),
        .frames_o      (frames),
        .value_errs_o  (value_errs),
        .flow_errs_o   (flow_errs)
    );

    always #5 clk = ~clk;

    function automatic row_t make_row(input logic [1:0] code, input int amp,
                                      input logic gapped, input int hold);
        row_t r;
        r.code   = code;
        r.amp    = fft_pkg::in_word_t'(amp);
        r.gapped = gapped;
        r.hold   = 8'(hold);
        return r;
    endfunction

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic fft_pkg::in_sample_t sample_of(input row_t r, input int n);
        fft_pkg::in_sample_t s;
        s = '0;
        case (r.code)
            PAT_IMPULSE:
            begin
                if (n == 0)
                    s.re = r.amp;
            end
            PAT_CONSTANT:
                s.re = r.amp;
            PAT_ALTERNATE:
                s.re = n[0] ? -r.amp : r.amp;
            default:
            begin
                // A, jA, -A, -jA turns a quarter cycle per sample, bin 4
                case (n % 4)
                    0: s.re = r.amp;
                    1: s.im = r.amp;
                    2: s.re = -r.amp;
                    default: s.im = -r.amp;
                endcase
            end
        endcase
        return s;
    endfunction

    task automatic finish_run();
        $display("errors: value %0d, flow %0d, testbench %0d", value_errs, flow_errs, tb_errs);
        if (value_errs + flow_errs + tb_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    task automatic wait_ready(input int row);
        int cycles;
        cycles = 0;
        while (!in_ready && cycles < READY_LIMIT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!in_ready)
        begin
            $display("time %0t: in_ready_o stayed low while waiting for frame slot %0d",
                     $time, row);
            tb_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic send_frame(input row_t r);
        cur_code = r.code;
        cur_amp  = r.amp;
        for (int n = 0; n < fft_pkg::N_POINTS; n++)
        begin
            in_valid    = 1'b1;
            din         = sample_of(r, n);
            frame_start = (n == 0);
            @(posedge clk);
            #1;
        end
        in_valid    = 1'b0;
        din         = '0;
        frame_start = 1'b0;
    endtask

    task automatic return_credits(input row_t r);
        int   sent;
        int   cycles;
        logic want;
        sent   = 0;
        cycles = 0;
        repeat (r.hold)
        begin
            @(posedge clk);
            #1;
        end
        while (sent < fft_pkg::N_POINTS && cycles < CREDIT_LIMIT)
        begin
            want = 1'b1;
            if (r.gapped)
            begin
                lfsr = lfsr_step(lfsr);
                want = lfsr[0];
            end
            // never push the buffer's count past its maximum
            credit = want && (held < fft_pkg::CREDIT_MAX);
            if (credit)
                sent++;
            @(posedge clk);
            #1;
            cycles++;
        end
        credit = 1'b0;
        if (sent < fft_pkg::N_POINTS)
        begin
            $display("time %0t: the buffer stopped taking credits after %0d of them", $time, sent);
            tb_errs++;
            aborted = 1'b1;
        end
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        din         = '0;
        credit      = 1'b0;
        frame_start = 1'b0;
        cur_code    = '0;
        cur_amp     = '0;
        lfsr        = 16'(LFSR_SEED);
        tb_errs     = 0;
        aborted     = 1'b0;
        stim[0] = make_row(PAT_IMPULSE, 1000, 1'b0, 20);
        stim[1] = make_row(PAT_CONSTANT, 100, 1'b0, 0);
        stim[2] = make_row(PAT_ALTERNATE, 1500, 1'b0, 0);
        stim[3] = make_row(PAT_ROTATE, -700, 1'b0, 0);
        stim[4] = make_row(PAT_IMPULSE, -2047, 1'b1, 0);
        stim[5] = make_row(PAT_CONSTANT, -128, 1'b1, 0);
        stim[6] = make_row(PAT_ALTERNATE, 2047, 1'b1, 0);
        stim[7] = make_row(PAT_ROTATE, 1234, 1'b1, 40);
        stim[8] = make_row(PAT_CONSTANT, 2047, 1'b0, 0);
        stim[9] = make_row(PAT_ROTATE, -2047, 1'b1, 0);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (out_valid !== 1'b0)
        begin
            $display("Error at time %0t: out_valid_o is %b, expected 0", $time, out_valid);
            tb_errs++;
        end
        if (in_ready !== 1'b1)
        begin
            $display("Error at time %0t: in_ready_o is %b, expected 1", $time, in_ready);
            tb_errs++;
        end

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            wait_ready(i);
            if (aborted)
                break;
            fork
                send_frame(stim[i]);
                return_credits(stim[i]);
            join
            if (aborted)
                break;
        end
        if (!aborted)
        begin
            // last frame has drained once the buffer is ready again
            wait_ready(NUM_ROWS);
            @(posedge clk);
            #1;
        end

        if (frames != NUM_ROWS)
        begin
            $display("only %0d of %0d frames came out complete", frames, NUM_ROWS);
            tb_errs++;
        end
        finish_run();
    end

endmodule

/* compile.f */
source/fft_pkg.sv
source/delay_line.sv
source/twiddle_rotator.sv
source/mdc_stage.sv
source/fft_ctrl.sv
source/reorder_buffer.sv
source/fft_top.sv
tb/fft_checker.sv
tb/tb_fft.sv

/* run.sh */
#!/bin/sh
# builds the FFT testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_fft -f compile.f -o tb_fft

out=$(./obj_dir/tb_fft)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
